// File: compile.f
rtl/mipsOpPkg.sv
rtl/memPkg.sv
rtl/memBus.sv
rtl/memRequest.sv
rtl/dataMemory.sv
rtl/loadAlign.sv
rtl/memAccessUnit.sv
verif/memAccessUnitChk.sv
verif/memAccessUnitTb.sv

// File: Makefile
TOP = memAccessUnitTb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f compile.f -Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP)

clean:
	rm -rf $(OBJ)

// File: verif/memAccessUnitTb.sv
module memAccessUnitTb;

    logic        clk;
    logic        rst;
    logic        reqValid;
    logic [31:0] instrWord;
    logic [31:0] address;
    logic [31:0] regData;
    logic [31:0] loadResult;
    logic        resultValid;

    // stimulus and expected values, one request per entry
    string       nameQ[$];
    logic [31:0] instrQ[$];
    logic [31:0] addrQ[$];
    logic [31:0] dataQ[$];
    bit          hasResultQ[$];
    logic [31:0] valueQ[$];

    memAccessUnit #(
        .memDepth (memPkg::DEFAULT_DEPTH)
    ) memAccessUnit_i (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (reqValid),
        .instrWord   (instrWord),
        .address     (address),
        .regData     (regData),
        .loadResult  (loadResult),
        .resultValid (resultValid)
    );

    bind memAccessUnit memAccessUnitChk chk_i (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (reqValid),
        .resultValid (resultValid),
        .loadResult  (loadResult)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // period 100
    end

    // I-type word, rs and rt left at zero
    function automatic logic [31:0] encodeInstr(input mipsOpPkg::opcodeT op,
                                                input logic [15:0] imm);
        return {op, 10'd0, imm};
    endfunction

    task automatic stopRun(input string reason);
        $display("test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            stopRun("load result mismatch");
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected resultValid %b, actual %b", name, expected, actual);
            stopRun("resultValid mismatch");
        end
    endtask

    // poll at the falling edge until the result strobe is low
    task automatic waitIdle(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (resultValid !== 1'b0)
        begin
            cycles++;
            if (cycles >= 20)
            begin
                $display("timeout: resultValid stayed high %s", what);
                stopRun("timeout waiting for idle");
            end
            @(negedge clk);
        end
    endtask

    task automatic addEntry(input string name, input mipsOpPkg::opcodeT op,
                            input logic [15:0] imm, input logic [31:0] addr,
                            input logic [31:0] data, input bit hasResult,
                            input logic [31:0] value);
        nameQ.push_back(name);
        instrQ.push_back(encodeInstr(op, imm));
        addrQ.push_back(addr);
        dataQ.push_back(data);
        hasResultQ.push_back(hasResult);
        valueQ.push_back(value);
    endtask

    // expected values worked out from the lane and extension rules
    task automatic buildTable;
        addEntry("sw word",        mipsOpPkg::OP_SW,  16'h0, 32'h10, 32'h8badf00d, 1'b0, 32'h0);
        addEntry("lw word",        mipsOpPkg::OP_LW,  16'h0, 32'h10, 32'h0, 1'b1, 32'h8badf00d);
        addEntry("lw low bits",    mipsOpPkg::OP_LW,  16'h0, 32'h13, 32'h0, 1'b1, 32'h8badf00d);
        addEntry("lw zero word",   mipsOpPkg::OP_LW,  16'h0, 32'h80, 32'h0, 1'b1, 32'h0);
        // byte merge into a zeroed word, upper regData bits must not leak
        addEntry("sb lane 0",      mipsOpPkg::OP_SB,  16'h0, 32'h20, 32'h00000011, 1'b0, 32'h0);
        addEntry("sb lane 1",      mipsOpPkg::OP_SB,  16'h0, 32'h21, 32'haaaaaa22, 1'b0, 32'h0);
        addEntry("sb lane 2",      mipsOpPkg::OP_SB,  16'h0, 32'h22, 32'h55555533, 1'b0, 32'h0);
        addEntry("lw three lanes", mipsOpPkg::OP_LW,  16'h0, 32'h20, 32'h0, 1'b1, 32'h00332211);
        addEntry("sb lane 3",      mipsOpPkg::OP_SB,  16'h0, 32'h23, 32'h00000044, 1'b0, 32'h0);
        addEntry("lw merged",      mipsOpPkg::OP_LW,  16'h0, 32'h20, 32'h0, 1'b1, 32'h44332211);
        // 0x80 and 0x7f in every lane over two words
        addEntry("sw pattern a",   mipsOpPkg::OP_SW,  16'h0, 32'h30, 32'h7f807f80, 1'b0, 32'h0);
        addEntry("sw pattern b",   mipsOpPkg::OP_SW,  16'h0, 32'h34, 32'h807f807f, 1'b0, 32'h0);
        addEntry("lb lane 0 neg",  mipsOpPkg::OP_LB,  16'h0, 32'h30, 32'h0, 1'b1, 32'hffffff80);
        addEntry("lbu lane 0 neg", mipsOpPkg::OP_LBU, 16'h0, 32'h30, 32'h0, 1'b1, 32'h00000080);
        addEntry("lb lane 1 pos",  mipsOpPkg::OP_LB,  16'h0, 32'h31, 32'h0, 1'b1, 32'h0000007f);
        addEntry("lbu lane 1 pos", mipsOpPkg::OP_LBU, 16'h0, 32'h31, 32'h0, 1'b1, 32'h0000007f);
        addEntry("lb lane 2 neg",  mipsOpPkg::OP_LB,  16'h0, 32'h32, 32'h0, 1'b1, 32'hffffff80);
        addEntry("lbu lane 2 neg", mipsOpPkg::OP_LBU, 16'h0, 32'h32, 32'h0, 1'b1, 32'h00000080);
        addEntry("lb lane 3 pos",  mipsOpPkg::OP_LB,  16'h0, 32'h33, 32'h0, 1'b1, 32'h0000007f);
        addEntry("lbu lane 3 pos", mipsOpPkg::OP_LBU, 16'h0, 32'h33, 32'h0, 1'b1, 32'h0000007f);
        addEntry("lb lane 0 pos",  mipsOpPkg::OP_LB,  16'h0, 32'h34, 32'h0, 1'b1, 32'h0000007f);
        addEntry("lb lane 1 neg",  mipsOpPkg::OP_LB,  16'h0, 32'h35, 32'h0, 1'b1, 32'hffffff80);
        addEntry("lbu lane 1 neg", mipsOpPkg::OP_LBU, 16'h0, 32'h35, 32'h0, 1'b1, 32'h00000080);
        addEntry("lb lane 2 pos",  mipsOpPkg::OP_LB,  16'h0, 32'h36, 32'h0, 1'b1, 32'h0000007f);
        addEntry("lb lane 3 neg",  mipsOpPkg::OP_LB,  16'h0, 32'h37, 32'h0, 1'b1, 32'hffffff80);
        addEntry("lbu lane 3 neg", mipsOpPkg::OP_LBU, 16'h0, 32'h37, 32'h0, 1'b1, 32'h00000080);
        // halfwords, address bit 0 ignored
        addEntry("sh low",         mipsOpPkg::OP_SH,  16'h0, 32'h40, 32'hdead8001, 1'b0, 32'h0);
        addEntry("sh high",        mipsOpPkg::OP_SH,  16'h0, 32'h42, 32'h00007ffe, 1'b0, 32'h0);
        addEntry("lh low neg",     mipsOpPkg::OP_LH,  16'h0, 32'h40, 32'h0, 1'b1, 32'hffff8001);
        addEntry("lhu low bit 0",  mipsOpPkg::OP_LHU, 16'h0, 32'h41, 32'h0, 1'b1, 32'h00008001);
        addEntry("lh high pos",    mipsOpPkg::OP_LH,  16'h0, 32'h42, 32'h0, 1'b1, 32'h00007ffe);
        addEntry("lhu high bit 0", mipsOpPkg::OP_LHU, 16'h0, 32'h43, 32'h0, 1'b1, 32'h00007ffe);
        addEntry("lw halves",      mipsOpPkg::OP_LW,  16'h0, 32'h40, 32'h0, 1'b1, 32'h7ffe8001);
        addEntry("sh high bit 0",  mipsOpPkg::OP_SH,  16'h0, 32'h47, 32'h12348001, 1'b0, 32'h0);
        addEntry("lh high neg",    mipsOpPkg::OP_LH,  16'h0, 32'h46, 32'h0, 1'b1, 32'hffff8001);
        addEntry("lhu high",       mipsOpPkg::OP_LHU, 16'h0, 32'h47, 32'h0, 1'b1, 32'h00008001);
        addEntry("lh low zero",    mipsOpPkg::OP_LH,  16'h0, 32'h44, 32'h0, 1'b1, 32'h0);
        // no memory access for these two
        addEntry("lui",            mipsOpPkg::OP_LUI, 16'h1234, 32'h10, 32'hffffffff, 1'b1,
                 32'h12340000);
        addEntry("ignored opcode", 6'd0,              16'h0, 32'h10, 32'hffffffff, 1'b0, 32'h0);
        addEntry("lw untouched",   mipsOpPkg::OP_LW,  16'h0, 32'h10, 32'h0, 1'b1, 32'h8badf00d);
        // back to back loads, each returns its own word
        addEntry("b2b lw 20",      mipsOpPkg::OP_LW,  16'h0, 32'h20, 32'h0, 1'b1, 32'h44332211);
        addEntry("b2b lw 44",      mipsOpPkg::OP_LW,  16'h0, 32'h44, 32'h0, 1'b1, 32'h80010000);
        addEntry("b2b lw 30",      mipsOpPkg::OP_LW,  16'h0, 32'h30, 32'h0, 1'b1, 32'h7f807f80);
        addEntry("b2b lw 34",      mipsOpPkg::OP_LW,  16'h0, 32'h34, 32'h0, 1'b1, 32'h807f807f);
    endtask

    initial
    begin
        int n;
        rst       = 1'b1;
        reqValid  = 1'b0;
        instrWord = '0;
        address   = '0;
        regData   = '0;
        buildTable();
        n = nameQ.size();

        repeat (16) @(posedge clk);     // 16 cycles of reset
        #10 rst = 1'b0;
        waitIdle("after reset");
        checkFlag("after reset", 1'b0, resultValid);

        // entry i goes out this cycle, entry i-1 is checked at the falling edge
        for (int i = 0; i <= n; i++)
        begin
            @(posedge clk);
            #10;
            if (i < n)
            begin
                reqValid  = 1'b1;
                instrWord = instrQ[i];
                address   = addrQ[i];
                regData   = dataQ[i];
            end
            else
            begin
                reqValid  = 1'b0;   // drain cycle
                instrWord = '0;
                address   = '0;
                regData   = '0;
            end
            @(negedge clk);
            if (i > 0)
            begin
                checkFlag(nameQ[i-1], hasResultQ[i-1], resultValid);
                if (hasResultQ[i-1])
                    checkWord(nameQ[i-1], valueQ[i-1], loadResult);
            end
        end

        waitIdle("after the last request");

        $display("test passed");
        $finish;
    end

endmodule

// File: verif/memAccessUnitChk.sv
module memAccessUnitChk (
    input logic        clk,
    input logic        rst,
    input logic        reqValid,
    input logic        resultValid,
    input logic [31:0] loadResult
);

    // a reset edge always leaves the result strobe low
    resetQuiet: assert property (@(posedge clk) rst |=> !resultValid)
        else $error("resultValid high in the cycle after a reset edge");

    // every result pulse belongs to a request one cycle back
    resultFollowsReq: assert property (
        @(posedge clk) disable iff (rst)
        resultValid |-> $past(reqValid)
    )
        else $error("resultValid without a request on the previous cycle");

    // result word fully known while it is flagged valid
    resultKnown: assert property (
        @(posedge clk) disable iff (rst)
        resultValid |-> !$isunknown(loadResult)
    )
        else $error("loadResult has unknown bits while resultValid is high");

endmodule

// File: rtl/memAccessUnit.sv
module memAccessUnit #(
    parameter int memDepth = memPkg::DEFAULT_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reqValid,     // one cycle per request
    input  logic [31:0]               instrWord,
    input  logic [memPkg::ADDR_W-1:0] address,      // byte address
    input  logic [31:0]               regData,      // store source
    output logic [31:0]               loadResult,
    output logic                      resultValid   // one cycle after a load or LUI
);

    // load context held for the result cycle
    mipsOpPkg::opcodeT  pendOpcode;
    memPkg::byteOffsetT pendOffset;
    logic [15:0]        pendImm;

    // request to ram
    memBus #(
        .memDepth (memDepth)
    ) bus ();

    // decode, strobes, store lanes
    memRequest #(
        .memDepth (memDepth)
    ) request_i (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .instrWord  (instrWord),
        .address    (address),
        .regData    (regData),
        .bus        (bus.requester),
        .pendOpcode (pendOpcode),
        .pendOffset (pendOffset),
        .pendImm    (pendImm),
        .pendValid  (resultValid)   // already limited to loads and LUI
    );

    // byte enabled ram
    dataMemory #(
        .memDepth (memDepth)
    ) memory_i (
        .clk (clk),
        .bus (bus.memory)
    );

    // lane pick and extension
    loadAlign align_i (
        .opcode   (pendOpcode),
        .offset   (pendOffset),
        .imm      (pendImm),
        .readData (bus.readData),
        .result   (loadResult)
    );

    // two loads can overlap
    // the second is issued while the first is read back
    // each one sees its own context register and read word

endmodule

// File: rtl/loadAlign.sv
module loadAlign (
    input  mipsOpPkg::opcodeT   opcode,
    input  memPkg::byteOffsetT  offset,
    input  logic [15:0]         imm,
    input  memPkg::dataWordT    readData,
    output logic [31:0]         result
);

    logic [7:0]  pickedByte;    // lane named by the offset
    logic [15:0] pickedHalf;    // half named by offset bit 1
    logic        byteSign;
    logic        halfSign;

    // lane select through the two union views
    assign pickedByte = readData.bytes[offset];
    assign pickedHalf = readData.halves[offset[1]];    // bit 0 ignored

    assign byteSign = pickedByte[mipsOpPkg::BYTE_MSB];
    assign halfSign = pickedHalf[mipsOpPkg::HALF_MSB];

    // format by opcode, picked lane always ends up in the low bits
    always_comb
    begin
        case (opcode)
            mipsOpPkg::OP_LW:
                result = readData;  // whole word, no shift
            mipsOpPkg::OP_LB:
            begin
                // 0x80 in any lane gives 0xffffff80
                result = {{24{byteSign}}, pickedByte};
            end
            mipsOpPkg::OP_LBU:
            begin
                result = {24'h000000, pickedByte};  // zero fill
            end
            mipsOpPkg::OP_LH:
            begin
                result = {{16{halfSign}}, pickedHalf};
            end
            mipsOpPkg::OP_LHU:
            begin
                result = {16'h0000, pickedHalf};
            end
            mipsOpPkg::OP_LUI:
            begin
                // immediate to the top half, low half cleared
                result = {imm, 16'h0000};
            end
            default:
                result = '0;    // stores and unknowns never reach the output
        endcase
    end

    // byte lanes in the word
    //   31:24 | 23:16 | 15:8 | 7:0
    //     3       2      1     0
    // halfwords
    //   halves[1] = 31:16, halves[0] = 15:0
    // offset comes from the request cycle
    // and readData from the following one
    // both line up in the result cycle
    // result is only meaningful while resultValid is high

endmodule

// File: rtl/dataMemory.sv
module dataMemory #(
    parameter int memDepth = memPkg::DEFAULT_DEPTH
) (
    input  logic     clk,
    memBus.memory    bus
);

    // word storage
    memPkg::dataWordT mem [memDepth];

    // power-up contents all zero
    initial
    begin
        for (int i = 0; i < memDepth; i++)
            mem[i] = '0;
    end

    // byte lane writes
    always_ff @(posedge clk)
    begin
        if (bus.writeEn)
        begin
            for (int lane = 0; lane < memPkg::LANES; lane++)
            begin
                if (bus.byteEn[lane])   // untouched lanes keep old data
                    mem[bus.wordAddr].bytes[lane] <= bus.writeData.bytes[lane];
            end
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk)
    begin
        if (bus.readEn)
            bus.readData <= mem[bus.wordAddr];
    end

    // read data holds between reads so a stale word
    // may sit on readData while no load is pending
    // the request stage never issues a read and a write
    // in the same cycle, so no collision handling is needed
    // a store followed by a load on the next cycle
    // reads the merged word since the write lands first

endmodule

// File: rtl/memRequest.sv
module memRequest #(
    parameter int memDepth = memPkg::DEFAULT_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reqValid,
    input  logic [31:0]               instrWord,
    input  logic [memPkg::ADDR_W-1:0] address,
    input  logic [31:0]               regData,
    memBus.requester                  bus,
    output mipsOpPkg::opcodeT         pendOpcode,
    output memPkg::byteOffsetT        pendOffset,
    output logic [15:0]               pendImm,
    output logic                      pendValid
);

    localparam int addrW = $clog2(memDepth);

    mipsOpPkg::opcodeT  opcode;
    memPkg::byteOffsetT offset;
    memPkg::byteEnT     byteEn;
    memPkg::dataWordT   storeWord;
    logic               isLoad;
    logic               isStore;
    logic               isLui;

    assign opcode = instrWord[mipsOpPkg::OPCODE_MSB:mipsOpPkg::OPCODE_LSB];
    assign offset = address[1:0];   // address % 4

    // decode plus store lane placement
    always_comb
    begin
        isLoad    = 1'b0;
        isStore   = 1'b0;
        isLui     = 1'b0;
        byteEn    = '0;
        storeWord = regData;    // SW takes the register as is
        case (opcode)
            mipsOpPkg::OP_LB, mipsOpPkg::OP_LBU,
            mipsOpPkg::OP_LH, mipsOpPkg::OP_LHU,
            mipsOpPkg::OP_LW:
                isLoad = 1'b1;
            mipsOpPkg::OP_LUI:
                isLui = 1'b1;   // no memory access
            mipsOpPkg::OP_SB:
            begin
                isStore = 1'b1;
                // low byte copied into every lane, strobe picks one
                for (int i = 0; i < memPkg::LANES; i++)
                    storeWord.bytes[i] = regData[7:0];
                byteEn = memPkg::byteEnT'(1) << offset;
            end
            mipsOpPkg::OP_SH:
            begin
                isStore = 1'b1;
                storeWord.halves[0] = regData[15:0];
                storeWord.halves[1] = regData[15:0];
                // bit 0 of the address plays no part
                byteEn = offset[1] ? memPkg::HIGH_HALF : memPkg::LOW_HALF;
            end
            mipsOpPkg::OP_SW:
            begin
                isStore = 1'b1;
                byteEn  = memPkg::ALL_LANES;    // bits 1:0 ignored
            end
            default: ;  // anything else is dropped
        endcase
    end

    // memory side, same cycle as the request
    assign bus.writeEn   = reqValid & isStore;
    assign bus.readEn    = reqValid & isLoad;
    assign bus.wordAddr  = address[addrW+1:2];
    assign bus.byteEn    = byteEn;
    assign bus.writeData = storeWord;

    // load context, lines up with readData on the next cycle
    always_ff @(posedge clk)
    begin
        if (reqValid)
        begin
            pendOpcode <= opcode;
            pendOffset <= offset;
            pendImm    <= instrWord[mipsOpPkg::IMM_MSB:0];
        end
    end

    // result pulse only for loads and LUI, stores stay silent
    always_ff @(posedge clk)
    begin
        if (rst)
            pendValid <= 1'b0;
        else
            pendValid <= reqValid & (isLoad | isLui);
    end

endmodule

// File: rtl/memBus.sv
interface memBus #(
    parameter int memDepth = memPkg::DEFAULT_DEPTH
);

    localparam int addrW = $clog2(memDepth);   // word index bits

    logic                 writeEn;    // one cycle, store
    logic                 readEn;     // one cycle, load
    logic [addrW-1:0]     wordAddr;   // byte address with bits 1:0 dropped
    memPkg::byteEnT       byteEn;     // lanes touched by a store
    memPkg::dataWordT     writeData;  // store data already lane shifted
    memPkg::dataWordT     readData;   // valid one edge after readEn

    // request side drives everything but the read word
    modport requester (
        output writeEn, readEn, wordAddr, byteEn, writeData,
        input  readData
    );

    // ram side
    modport memory (
        input  writeEn, readEn, wordAddr, byteEn, writeData,
        output readData
    );

endinterface

// File: rtl/memPkg.sv
package memPkg;

    // byte address width
    localparam int ADDR_W = 32;

    // memory size in words unless the top level says otherwise
    localparam int DEFAULT_DEPTH = 256;

    // lanes in a word
    localparam int LANES = 4;

    // one strobe per byte lane, bit 0 is bits 7:0
    typedef logic [LANES-1:0] byteEnT;

    // low address bits naming the lane
    typedef logic [1:0] byteOffsetT;

    // one data word, seen as bytes or as halfwords
    // little endian lanes, bytes[0] is bits 7:0
    typedef union packed {
        logic [LANES-1:0][7:0] bytes;   // lane view
        logic [1:0][15:0]      halves;  // halves[1] is the upper half
    } dataWordT;

    // a full store touches every lane
    localparam byteEnT ALL_LANES = '1;

    // halfword strobes, picked by address bit 1
    localparam byteEnT LOW_HALF  = 4'b0011;
    localparam byteEnT HIGH_HALF = 4'b1100;

endpackage

// File: rtl/mipsOpPkg.sv
package mipsOpPkg;

    // primary opcode, instr bits 31:26
    typedef logic [5:0] opcodeT;

    // where the fields sit in an I-type word
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam int IMM_MSB    = 15;     // immediate is bits 15:0

    // loads
    localparam opcodeT OP_LB  = 6'd32;  // 100000
    localparam opcodeT OP_LH  = 6'd33;  // 100001
    localparam opcodeT OP_LW  = 6'd35;  // 100011
    localparam opcodeT OP_LBU = 6'd36;  // 100100
    localparam opcodeT OP_LHU = 6'd37;  // 100101

    // stores
    localparam opcodeT OP_SB  = 6'd40;  // 101000
    localparam opcodeT OP_SH  = 6'd41;  // 101001
    localparam opcodeT OP_SW  = 6'd43;  // 101011

    // upper immediate, rides the load path without a memory access
    localparam opcodeT OP_LUI = 6'd15;  // 001111

    // LWL (34) and LWR (38) are not supported
    // an unknown opcode is simply dropped by the request stage

    // sign of a byte or halfword sits in its top bit
    localparam int BYTE_MSB = 7;
    localparam int HALF_MSB = 15;

endpackage
